//--- source/fpga_wrapper_pkg.sv
/*
 * Shared types, register map and sizing for the FPGA support wrapper.
 * All RTL refers to these by scoped name, e.g. fpga_wrapper_pkg::reg_data_t.
 */

package fpga_wrapper_pkg;

    // Register port payloads
    typedef logic [3:0]  reg_addr_t;    // Word address
    typedef logic [31:0] reg_data_t;

    // FIFO payloads
    typedef logic [7:0]  log_char_t;
    typedef logic [31:0] trng_word_t;   // As written by software
    typedef logic [3:0]  trng_nibble_t; // As delivered to the consumer

    // Entropy output bookkeeping
    typedef logic [3:0]  credit_cnt_t;
    typedef logic [2:0]  nibble_idx_t;  // Selects one nibble of the head word

    localparam int LOG_FIFO_DEPTH   = 16;
    localparam int TRNG_FIFO_DEPTH  = 8;
    localparam int TRNG_CREDIT_MAX  = 8;
    localparam int NIBBLES_PER_WORD = $bits(trng_word_t) / $bits(trng_nibble_t);

    localparam reg_data_t FPGA_VERSION = 32'h0001_0200;

    // Register map
    localparam reg_addr_t ADDR_VERSION      = 4'd0;
    localparam reg_addr_t ADDR_CONTROL      = 4'd1;
    localparam reg_addr_t ADDR_TRNG_DIVISOR = 4'd2;
    localparam reg_addr_t ADDR_TRNG_DATA    = 4'd3; // Write only
    localparam reg_addr_t ADDR_STATUS       = 4'd4;
    localparam reg_addr_t ADDR_LOG_DATA     = 4'd5; // Read pops
    localparam reg_addr_t ADDR_CYCLE_COUNT  = 4'd6;

    // Control register fields
    localparam int CTRL_CORE_RUN        = 0;
    localparam int CTRL_TRNG_FIFO_RESET = 1; // Holds entropy path empty while set

    // Status register fields
    localparam int STAT_LOG_EMPTY  = 0;
    localparam int STAT_LOG_FULL   = 1;
    localparam int STAT_TRNG_EMPTY = 2;
    localparam int STAT_TRNG_FULL  = 3;

    // Log data word, char in [7:0]
    localparam int LOG_VALID_BIT = 8;

endpackage

//--- source/sync_fifo.sv
/*
 * First-word-fall-through synchronous FIFO, payload given by type parameter.
 * Head entry is visible combinationally; pop advances it at the clock edge.
 */

`timescale 1ns/100ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic     core_clk,
    input  logic     hwif_out,
    input  logic     flush,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);

    payload_t                     mem [DEPTH];
    logic [$clog2(DEPTH)-1:0]     wr_ptr;
    logic [$clog2(DEPTH)-1:0]     rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;  // Occupancy
    logic                         do_push;
    logic                         do_pop;

    // Overflow and underflow requests are dropped here
    assign do_push = push && !full && !flush;
    assign do_pop  = pop && !empty && !flush;

    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == DEPTH);

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

    // Storage array
    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

//--- source/wrapper_regs.sv
/*
 * Register block of the wrapper: decode, control and divisor registers,
 * status, cycle counter, log FIFO readout and entropy FIFO fill.
 * Reads return data with reg_rvalid exactly one cycle after reg_rd.
 */

`timescale 1ns/100ps

module wrapper_regs (
    input  logic                         core_clk,
    input  logic                         hwif_out,

    // Register strobe port
    input  logic                         reg_wr,
    input  logic                         reg_rd,
    input  fpga_wrapper_pkg::reg_addr_t  reg_addr,
    input  fpga_wrapper_pkg::reg_data_t  reg_wdata,
    output fpga_wrapper_pkg::reg_data_t  reg_rdata,
    output logic                         reg_rvalid,

    // Log character input
    input  logic                         log_valid,
    input  fpga_wrapper_pkg::log_char_t  log_char,

    // To the entropy feeder
    output fpga_wrapper_pkg::reg_data_t  trng_divisor,
    output logic                         trng_flush,
    output fpga_wrapper_pkg::trng_word_t fifo_word,
    output logic                         fifo_empty,
    input  logic                         fifo_pop
);

    fpga_wrapper_pkg::reg_data_t control;
    fpga_wrapper_pkg::reg_data_t divisor;
    fpga_wrapper_pkg::reg_data_t cycle_count;
    fpga_wrapper_pkg::reg_data_t status;
    fpga_wrapper_pkg::reg_data_t rdata_next;
    fpga_wrapper_pkg::log_char_t log_head;
    logic                        log_empty;
    logic                        log_full;
    logic                        log_pop;
    logic                        trng_push;
    logic                        trng_full;

    assign trng_divisor = divisor;
    assign trng_flush   = control[fpga_wrapper_pkg::CTRL_TRNG_FIFO_RESET];

    // Reading the log data register consumes the head character
    assign log_pop   = reg_rd && (reg_addr == fpga_wrapper_pkg::ADDR_LOG_DATA);
    assign trng_push = reg_wr && (reg_addr == fpga_wrapper_pkg::ADDR_TRNG_DATA);

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            control <= '0;
            divisor <= '0;
        end else if (reg_wr) begin
            if (reg_addr == fpga_wrapper_pkg::ADDR_CONTROL) begin
                control <= reg_wdata;
            end
            if (reg_addr == fpga_wrapper_pkg::ADDR_TRNG_DIVISOR) begin
                divisor <= reg_wdata;
            end
        end
    end

    // Free-running while the core is released
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            cycle_count <= '0;
        end else if (!control[fpga_wrapper_pkg::CTRL_CORE_RUN]) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    always_comb begin
        status = '0;
        status[fpga_wrapper_pkg::STAT_LOG_EMPTY]  = log_empty;
        status[fpga_wrapper_pkg::STAT_LOG_FULL]   = log_full;
        status[fpga_wrapper_pkg::STAT_TRNG_EMPTY] = fifo_empty;
        status[fpga_wrapper_pkg::STAT_TRNG_FULL]  = trng_full;
    end

    // Read mux, unmapped and write-only addresses return zero
    always_comb begin
        rdata_next = '0;
        case (reg_addr)
            fpga_wrapper_pkg::ADDR_VERSION:      rdata_next = fpga_wrapper_pkg::FPGA_VERSION;
            fpga_wrapper_pkg::ADDR_CONTROL:      rdata_next = control;
            fpga_wrapper_pkg::ADDR_TRNG_DIVISOR: rdata_next = divisor;
            fpga_wrapper_pkg::ADDR_STATUS:       rdata_next = status;
            fpga_wrapper_pkg::ADDR_CYCLE_COUNT:  rdata_next = cycle_count;
            fpga_wrapper_pkg::ADDR_LOG_DATA: begin
                if (!log_empty) begin
                    rdata_next[$bits(fpga_wrapper_pkg::log_char_t)-1:0] = log_head;
                    rdata_next[fpga_wrapper_pkg::LOG_VALID_BIT]          = 1'b1;
                end
            end
            default: rdata_next = '0;
        endcase
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            reg_rvalid <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
        end
    end

    always_ff @(posedge core_clk) begin
        if (reg_rd) begin
            reg_rdata <= rdata_next; // Sampled in the read cycle
        end
    end

    sync_fifo #(
        .payload_t (fpga_wrapper_pkg::log_char_t),
        .DEPTH     (fpga_wrapper_pkg::LOG_FIFO_DEPTH)
    ) log_fifo (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .flush     (1'b0),
        .push      (log_valid),  // Dropped when full
        .push_data (log_char),
        .pop       (log_pop),
        .head      (log_head),
        .empty     (log_empty),
        .full      (log_full)
    );

    sync_fifo #(
        .payload_t (fpga_wrapper_pkg::trng_word_t),
        .DEPTH     (fpga_wrapper_pkg::TRNG_FIFO_DEPTH)
    ) trng_fifo (
        .core_clk  (core_clk),
        .hwif_out  (hwif_out),
        .flush     (trng_flush),
        .push      (trng_push),
        .push_data (reg_wdata),
        .pop       (fifo_pop),
        .head      (fifo_word),
        .empty     (fifo_empty),
        .full      (trng_full)
    );

endmodule

//--- source/trng_feeder.sv
/*
 * Unpacks entropy words into nibbles for the consumer, low nibble first.
 * A nibble goes out only with a credit held, data present and the throttle
 * counter at zero; each send reloads the throttle with the divisor.
 */

`timescale 1ns/100ps

module trng_feeder (
    input  logic                           core_clk,
    input  logic                           hwif_out,
    input  fpga_wrapper_pkg::reg_data_t    trng_divisor,
    input  logic                           trng_flush,
    input  fpga_wrapper_pkg::trng_word_t   fifo_word,
    input  logic                           fifo_empty,
    output logic                           fifo_pop,
    input  logic                           trng_credit,
    output logic                           trng_valid,
    output fpga_wrapper_pkg::trng_nibble_t trng_data
);

    fpga_wrapper_pkg::credit_cnt_t credit_cnt;
    fpga_wrapper_pkg::reg_data_t   throttle_cnt;
    fpga_wrapper_pkg::nibble_idx_t nibble_idx;
    logic                          send;
    logic                          last_nibble;

    assign send = (credit_cnt != '0) && !fifo_empty && (throttle_cnt == '0) && !trng_flush;

    assign last_nibble = (nibble_idx ==
                          fpga_wrapper_pkg::nibble_idx_t'(fpga_wrapper_pkg::NIBBLES_PER_WORD - 1));

    // Head word leaves the FIFO together with its last nibble
    assign fifo_pop = send && last_nibble;

    // Credit in and send out in one cycle cancel each other
    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            credit_cnt <= '0;
        end else begin
            case ({trng_credit, send})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            throttle_cnt <= '0;
        end else if (send) begin
            throttle_cnt <= trng_divisor;         // Spacing of divisor+1 cycles
        end else if (throttle_cnt != '0) begin
            throttle_cnt <= throttle_cnt - 1'b1;
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            nibble_idx <= '0;
        end else if (trng_flush) begin
            nibble_idx <= '0;                     // Partial word is discarded
        end else if (send) begin
            nibble_idx <= nibble_idx + 1'b1;      // Wraps after the last nibble
        end
    end

    always_ff @(posedge core_clk or negedge hwif_out) begin
        if (!hwif_out) begin
            trng_valid <= 1'b0;
        end else begin
            trng_valid <= send;
        end
    end

    always_ff @(posedge core_clk) begin
        if (send) begin
            trng_data <= fifo_word[nibble_idx * $bits(fpga_wrapper_pkg::trng_nibble_t) +:
                                   $bits(fpga_wrapper_pkg::trng_nibble_t)];
        end
    end

endmodule

//--- source/fpga_wrapper_top.sv
/*
 * Top level of the wrapper. Connects the register block to the entropy
 * feeder; the consumer grants nibbles with trng_credit pulses.
 */

`timescale 1ns/100ps

module fpga_wrapper_top (
    input  logic                           core_clk,
    input  logic                           hwif_out,

    input  logic                           reg_wr,
    input  logic                           reg_rd,
    input  fpga_wrapper_pkg::reg_addr_t    reg_addr,
    input  fpga_wrapper_pkg::reg_data_t    reg_wdata,
    output fpga_wrapper_pkg::reg_data_t    reg_rdata,
    output logic                           reg_rvalid,

    input  logic                           log_valid,
    input  fpga_wrapper_pkg::log_char_t    log_char,

    input  logic                           trng_credit,
    output logic                           trng_valid,
    output fpga_wrapper_pkg::trng_nibble_t trng_data
);

    fpga_wrapper_pkg::reg_data_t  trng_divisor;
    fpga_wrapper_pkg::trng_word_t fifo_word;
    logic                         trng_flush;
    logic                         fifo_empty;
    logic                         fifo_pop;

    wrapper_regs wrapper_regs_inst (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .reg_rvalid   (reg_rvalid),
        .log_valid    (log_valid),
        .log_char     (log_char),
        .trng_divisor (trng_divisor),
        .trng_flush   (trng_flush),
        .fifo_word    (fifo_word),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop)
    );

    // Entropy nibble stream
    trng_feeder trng_feeder_inst (
        .core_clk     (core_clk),
        .hwif_out     (hwif_out),
        .trng_divisor (trng_divisor),
        .trng_flush   (trng_flush),
        .fifo_word    (fifo_word),
        .fifo_empty   (fifo_empty),
        .fifo_pop     (fifo_pop),
        .trng_credit  (trng_credit),
        .trng_valid   (trng_valid),
        .trng_data    (trng_data)
    );

endmodule

//--- verification/trng_feeder_props.sv
/*
 * Concurrent checks on the entropy feeder, bound into every trng_feeder.
 * Each nibble needs a held credit and an idle throttle, and credits stay in range.
 */

`timescale 1ns/100ps

module trng_feeder_props (
    input logic                          core_clk,
    input logic                          hwif_out,
    input fpga_wrapper_pkg::credit_cnt_t credit_cnt,
    input fpga_wrapper_pkg::reg_data_t   throttle_cnt,
    input logic                          trng_valid
);

    int unsigned assert_fails = 0;

    // trng_valid lags the send decision by one cycle
    valid_needs_credit: assert property (@(posedge core_clk) disable iff (!hwif_out)
        trng_valid |-> ($past(credit_cnt) != '0)) else begin
        assert_fails = assert_fails + 1;
        $error("trng_valid issued with no credit held");
    end

    credit_in_range: assert property (@(posedge core_clk) disable iff (!hwif_out)
        credit_cnt <= fpga_wrapper_pkg::credit_cnt_t'(fpga_wrapper_pkg::TRNG_CREDIT_MAX))
        else begin
        assert_fails = assert_fails + 1;
        $error("credit count above the credit limit");
    end

    valid_needs_idle_throttle: assert property (@(posedge core_clk) disable iff (!hwif_out)
        trng_valid |-> ($past(throttle_cnt) == '0)) else begin
        assert_fails = assert_fails + 1;
        $error("trng_valid issued while the throttle was still counting");
    end

endmodule

bind trng_feeder trng_feeder_props feeder_props (
    .core_clk     (core_clk),
    .hwif_out     (hwif_out),
    .credit_cnt   (credit_cnt),
    .throttle_cnt (throttle_cnt),
    .trng_valid   (trng_valid)
);

//--- verification/tb_tasks.svh
/*
 * Register port, log input and compare tasks of the wrapper testbench.
 * Included inside the testbench module after its signal declarations.
 */

task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Run stopped on failure");
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected) begin
        $display("error: %s got 0x%08h expected 0x%08h", name, got, expected);
        $display("Test failed");
        $fatal(1, "Mismatch on %s", name);
    end
endtask

task automatic reg_write(input fpga_wrapper_pkg::reg_addr_t addr,
                         input fpga_wrapper_pkg::reg_data_t data);
    @(posedge core_clk);
    reg_wr    <= 1'b1;
    reg_addr  <= addr;
    reg_wdata <= data;
    @(posedge core_clk);
    reg_wr    <= 1'b0;
endtask

// Data is due exactly one cycle after the strobe
task automatic reg_read(input fpga_wrapper_pkg::reg_addr_t addr,
                        output fpga_wrapper_pkg::reg_data_t data);
    @(posedge core_clk);
    reg_rd   <= 1'b1;
    reg_addr <= addr;
    @(posedge core_clk);
    reg_rd   <= 1'b0;
    @(negedge core_clk);
    check_value("reg_rvalid", 32'(reg_rvalid), 32'd1);
    data = reg_rdata;
endtask

task automatic log_push(input fpga_wrapper_pkg::log_char_t ch);
    @(posedge core_clk);
    log_valid <= 1'b1;
    log_char  <= ch;
    if (log_q.size() < fpga_wrapper_pkg::LOG_FIFO_DEPTH) begin
        log_q.push_back(ch); // A full FIFO drops the character
    end
    @(posedge core_clk);
    log_valid <= 1'b0;
endtask

//--- verification/fpga_wrapper_tb.sv
/*
 * Testbench for the FPGA support wrapper. Drives the register port, the log
 * input and credit pulses with seeded random data, and checks reads and every
 * entropy nibble against a reference model of queues and shadow registers.
 */

`timescale 1ns/100ps

module fpga_wrapper_tb;

    localparam int TIMEOUT_CYCLES = 20000;

    logic                           core_clk;
    logic                           hwif_out;
    logic                           reg_wr;
    logic                           reg_rd;
    fpga_wrapper_pkg::reg_addr_t    reg_addr;
    fpga_wrapper_pkg::reg_data_t    reg_wdata;
    fpga_wrapper_pkg::reg_data_t    reg_rdata;
    logic                           reg_rvalid;
    logic                           log_valid;
    fpga_wrapper_pkg::log_char_t    log_char;
    logic                           trng_credit;
    logic                           trng_valid;
    fpga_wrapper_pkg::trng_nibble_t trng_data;

    fpga_wrapper_pkg::log_char_t    log_q[$];  // Characters still in the log FIFO
    fpga_wrapper_pkg::trng_nibble_t nib_q[$];  // Nibbles still owed on trng_data
    fpga_wrapper_pkg::reg_data_t    ctrl_shadow;
    fpga_wrapper_pkg::reg_data_t    div_shadow;
    int unsigned                    credits_granted = 0;
    int unsigned                    nibbles_seen = 0;
    int unsigned                    gap_base = 0;
    int unsigned                    last_nibble_cycle = 0;
    int unsigned                    cycle = 0;
    logic                           gap_check = 1'b0;

    `include "tb_tasks.svh"

    fpga_wrapper_top fpga_wrapper_top_inst (.*);

    initial begin
        core_clk = 1'b0;
        forever #5 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        cycle <= cycle + 1;
        if (cycle == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "Simulation timed out");
        end
    end

    // Entropy output monitor
    always @(negedge core_clk) begin
        if (hwif_out && trng_valid) begin
            nibbles_seen = nibbles_seen + 1;
            if (nibbles_seen > credits_granted) begin
                fail_run("More nibbles were sent than credits were granted");
            end
            if (nib_q.size() == 0) begin
                fail_run("trng_valid came with no entropy nibble pending");
            end
            check_value("trng_data", 32'(trng_data), 32'(nib_q.pop_front()));
            if (gap_check && nibbles_seen > gap_base + 1) begin
                check_value("trng_valid gap", cycle - last_nibble_cycle, div_shadow + 32'd1);
            end
            last_nibble_cycle = cycle;
        end
    end

    function automatic logic fifo_room();
        return ((nib_q.size() + 7) / 8) < fpga_wrapper_pkg::TRNG_FIFO_DEPTH;
    endfunction

    function automatic logic credit_room();
        return (credits_granted - nibbles_seen) < fpga_wrapper_pkg::TRNG_CREDIT_MAX;
    endfunction

    function automatic fpga_wrapper_pkg::reg_data_t log_word(input fpga_wrapper_pkg::log_char_t ch);
        fpga_wrapper_pkg::reg_data_t w;
        w = '0;
        w[7:0] = ch;
        w[fpga_wrapper_pkg::LOG_VALID_BIT] = 1'b1;
        return w;
    endfunction

    function automatic fpga_wrapper_pkg::reg_data_t status_word(input logic log_empty,
                                                                input logic log_full,
                                                                input logic trng_empty);
        fpga_wrapper_pkg::reg_data_t w;
        w = '0;
        w[fpga_wrapper_pkg::STAT_LOG_EMPTY]  = log_empty;
        w[fpga_wrapper_pkg::STAT_LOG_FULL]   = log_full;
        w[fpga_wrapper_pkg::STAT_TRNG_EMPTY] = trng_empty;
        return w;
    endfunction

    // One clock of entropy traffic with optional word write and credit pulse
    task automatic entropy_cycle(input logic do_write, input fpga_wrapper_pkg::trng_word_t word,
                                 input logic grant);
        @(posedge core_clk);
        reg_wr      <= do_write;
        reg_addr    <= fpga_wrapper_pkg::ADDR_TRNG_DATA;
        reg_wdata   <= word;
        trng_credit <= grant;
        if (do_write) begin
            for (int i = 0; i < fpga_wrapper_pkg::NIBBLES_PER_WORD; i++) begin
                nib_q.push_back(word[i*4 +: 4]); // Low nibble first
            end
        end
        if (grant) begin
            credits_granted = credits_granted + 1;
        end
    endtask

    task automatic drain_log();
        fpga_wrapper_pkg::reg_data_t rd;
        while (log_q.size() != 0) begin
            reg_read(fpga_wrapper_pkg::ADDR_LOG_DATA, rd);
            check_value("reg_rdata", rd, log_word(log_q.pop_front()));
        end
        reg_read(fpga_wrapper_pkg::ADDR_LOG_DATA, rd);
        check_value("reg_rdata", rd, 32'd0);
    endtask

    initial begin
        fpga_wrapper_pkg::reg_data_t rd;
        fpga_wrapper_pkg::reg_data_t first;
        int                          n;

        void'($urandom(32'hf011_9f15));
        hwif_out    = 1'b0;
        reg_wr      = 1'b0;
        reg_rd      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        log_valid   = 1'b0;
        log_char    = '0;
        trng_credit = 1'b0;
        ctrl_shadow = '0;
        div_shadow  = '0;
        repeat (8) @(posedge core_clk);
        hwif_out <= 1'b1;
        @(negedge core_clk);
        check_value("trng_valid", 32'(trng_valid), 32'd0);
        check_value("reg_rvalid", 32'(reg_rvalid), 32'd0);

        reg_read(fpga_wrapper_pkg::ADDR_VERSION, rd);
        check_value("reg_rdata", rd, fpga_wrapper_pkg::FPGA_VERSION);
        reg_read(fpga_wrapper_pkg::ADDR_TRNG_DATA, rd);
        check_value("reg_rdata", rd, 32'd0);
        for (int a = 7; a < 16; a++) begin
            reg_read(fpga_wrapper_pkg::reg_addr_t'(a), rd);
            check_value("reg_rdata", rd, 32'd0);
        end
        repeat (4) begin
            ctrl_shadow = $urandom;
            div_shadow  = $urandom;
            reg_write(fpga_wrapper_pkg::ADDR_CONTROL, ctrl_shadow);
            reg_write(fpga_wrapper_pkg::ADDR_TRNG_DIVISOR, div_shadow);
            reg_read(fpga_wrapper_pkg::ADDR_CONTROL, rd);
            check_value("reg_rdata", rd, ctrl_shadow);
            reg_read(fpga_wrapper_pkg::ADDR_TRNG_DIVISOR, rd);
            check_value("reg_rdata", rd, div_shadow);
        end
        ctrl_shadow = '0;
        reg_write(fpga_wrapper_pkg::ADDR_CONTROL, ctrl_shadow);

        // Log FIFO plain fill and then overflow
        n = $urandom_range(fpga_wrapper_pkg::LOG_FIFO_DEPTH, 1);
        repeat (n) log_push(8'($urandom));
        drain_log();
        repeat (fpga_wrapper_pkg::LOG_FIFO_DEPTH + 4) log_push(8'($urandom));
        reg_read(fpga_wrapper_pkg::ADDR_STATUS, rd);
        check_value("reg_rdata", rd, status_word(1'b0, 1'b1, 1'b1));
        drain_log();

        // Random entropy words against random credits
        div_shadow = $urandom_range(3, 0);
        reg_write(fpga_wrapper_pkg::ADDR_TRNG_DIVISOR, div_shadow);
        repeat (600) begin
            entropy_cycle(fifo_room() && ($urandom_range(3, 0) == 0), $urandom,
                          credit_room() && ($urandom_range(2, 0) == 0));
        end
        while (nib_q.size() != 0) entropy_cycle(1'b0, '0, credit_room());
        entropy_cycle(1'b0, '0, 1'b0);

        // Throttle spacing with credits kept topped up
        repeat (3) begin
            div_shadow = $urandom_range(5, 0);
            reg_write(fpga_wrapper_pkg::ADDR_TRNG_DIVISOR, div_shadow);
            gap_base  = nibbles_seen;
            gap_check = 1'b1;
            repeat (4) entropy_cycle(1'b1, $urandom, credit_room());
            while (nib_q.size() != 0) entropy_cycle(1'b0, '0, credit_room());
            gap_check = 1'b0;
            entropy_cycle(1'b0, '0, 1'b0);
        end

        // Leftover credits eat into two words, then none are held at the flush
        div_shadow = '0;
        reg_write(fpga_wrapper_pkg::ADDR_TRNG_DIVISOR, div_shadow);
        repeat (2) entropy_cycle(1'b1, $urandom, 1'b0);
        while (nibbles_seen != credits_granted) entropy_cycle(1'b0, '0, 1'b0);
        ctrl_shadow = fpga_wrapper_pkg::reg_data_t'(1) << fpga_wrapper_pkg::CTRL_TRNG_FIFO_RESET;
        reg_write(fpga_wrapper_pkg::ADDR_CONTROL, ctrl_shadow);
        nib_q.delete();
        ctrl_shadow = '0;
        reg_write(fpga_wrapper_pkg::ADDR_CONTROL, ctrl_shadow);
        reg_read(fpga_wrapper_pkg::ADDR_STATUS, rd);
        check_value("reg_rdata", rd, status_word(1'b1, 1'b0, 1'b1));
        repeat (20) entropy_cycle(1'b0, '0, credit_room());

        // A fresh word starts again from its low nibble
        entropy_cycle(1'b1, $urandom, credit_room());
        while (nib_q.size() != 0) entropy_cycle(1'b0, '0, credit_room());
        entropy_cycle(1'b0, '0, 1'b0);
        repeat (8) @(posedge core_clk);

        // Read strobes of the cycle counter are n+2 cycles apart
        ctrl_shadow = fpga_wrapper_pkg::reg_data_t'(1) << fpga_wrapper_pkg::CTRL_CORE_RUN;
        reg_write(fpga_wrapper_pkg::ADDR_CONTROL, ctrl_shadow);
        repeat (3) begin
            n = $urandom_range(30, 0);
            reg_read(fpga_wrapper_pkg::ADDR_CYCLE_COUNT, first);
            repeat (n) @(posedge core_clk);
            reg_read(fpga_wrapper_pkg::ADDR_CYCLE_COUNT, rd);
            check_value("reg_rdata", rd - first, fpga_wrapper_pkg::reg_data_t'(n + 2));
        end
        ctrl_shadow = '0;
        reg_write(fpga_wrapper_pkg::ADDR_CONTROL, ctrl_shadow);
        reg_read(fpga_wrapper_pkg::ADDR_CYCLE_COUNT, rd);
        check_value("reg_rdata", rd, 32'd0);

        if (fpga_wrapper_top_inst.trng_feeder_inst.feeder_props.assert_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- fpga_wrapper_top.f
+incdir+verification
source/fpga_wrapper_pkg.sv
source/sync_fifo.sv
source/wrapper_regs.sv
source/trng_feeder.sv
source/fpga_wrapper_top.sv
verification/trng_feeder_props.sv
verification/fpga_wrapper_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the wrapper testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fpga_wrapper_tb \
    -f fpga_wrapper_top.f -o fpga_wrapper_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/fpga_wrapper_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation returned status $sim_status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
